// ==== stack_cpu_pkg.sv ====
`default_nettype none

package stack_cpu_pkg;

  // ----------------------------------------------------------------------
  // sizes fixed by the instruction format
  // ----------------------------------------------------------------------
  localparam int data_w      = 8;   // data byte and data address width.
  localparam int pc_w        = 10;
  localparam int stack_depth = 8;

  // ----------------------------------------------------------------------
  // opcodes
  // ----------------------------------------------------------------------
  localparam logic [data_w-1:0] op_push  = 8'h01;
  localparam logic [data_w-1:0] op_out   = 8'h02;
  localparam logic [data_w-1:0] op_add   = 8'h03;
  localparam logic [data_w-1:0] op_sub   = 8'h04;
  localparam logic [data_w-1:0] op_mul   = 8'h05;
  localparam logic [data_w-1:0] op_store = 8'h06;
  localparam logic [data_w-1:0] op_load  = 8'h07;

  // the whole word is compared, not just the opcode byte.
  localparam logic [2*data_w-1:0] halt_word = 16'hffff;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [data_w-1:0] opcode;
    logic [data_w-1:0] operand;
  } insn_fields_t;

  // the sequencer looks at the raw word, the datapath at the fields.
  typedef union packed {
    logic [2*data_w-1:0] raw;
    insn_fields_t        fields;
  } insn_u;

  typedef enum logic [1:0] {
    ph_exec,
    ph_mem,
    ph_halt
  } phase_t;

  typedef struct packed {
    logic exec;
    logic mem;
  } ctrl_t;

  typedef struct packed {
    logic              we;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== cpu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer import stack_cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  insn_u insn,
  output ctrl_t ctrl,
  output logic  halted
);

  phase_t state_q;
  phase_t state_d;

  // ----------------------------------------------------------------------
  // phase register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= ph_exec;
    end else begin
      state_q <= state_d;
    end
  end

  // every instruction is one exec cycle followed by one mem cycle.
  always_comb begin
    state_d = state_q;
    case (state_q)
      ph_exec: begin
        if (insn.raw == halt_word) begin
          state_d = ph_halt; // the halt word never gets a mem cycle.
        end else begin
          state_d = ph_mem;
        end
      end
      ph_mem: begin
        state_d = ph_exec;
      end
      ph_halt: begin
        state_d = ph_halt;   // only reset leaves this state.
      end
      default: begin
        state_d = ph_exec;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // outputs decoded from the state
  // ----------------------------------------------------------------------
  always_comb begin
    ctrl.exec = (state_q == ph_exec);
    ctrl.mem  = (state_q == ph_mem);
  end

  // once halted, both ctrl bits stay low and the rest of the core freezes.
  assign halted = (state_q == ph_halt);

endmodule

`default_nettype wire

// ==== program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter import stack_cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  ctrl_t           ctrl,
  output logic [pc_w-1:0] pc
);

  // the counter moves on the edge that closes a mem cycle.
  // after a halt ctrl.mem never rises again, so pc stays on the halt word.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (ctrl.mem) begin
      pc <= pc + 1'b1; // wraps at the top of the range.
    end
  end

endmodule

`default_nettype wire

// ==== operand_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_stack import stack_cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  ctrl_t             ctrl,
  input  insn_u             insn,
  input  logic [data_w-1:0] rd_data,
  output mem_req_t          mem_req,
  output logic [data_w-1:0] reg0,
  output logic              reg0_wr
);

  logic [data_w-1:0]   stk [stack_depth]; // stk[0] is the top of stack.
  logic [data_w-1:0]   opcode;
  logic                is_push;
  logic                is_out;
  logic                is_arith;
  logic                is_store;
  logic                is_load;
  logic                load_pend;
  logic                push_en;
  logic                pop_en;
  logic [data_w-1:0]   push_val;
  logic [2*data_w-1:0] prod;
  logic [data_w-1:0]   alu_res;

  // ----------------------------------------------------------------------
  // decode during exec
  // ----------------------------------------------------------------------
  assign opcode = insn.fields.opcode;

  always_comb begin
    is_push  = ctrl.exec && (opcode == op_push);
    is_out   = ctrl.exec && (opcode == op_out);
    is_store = ctrl.exec && (opcode == op_store);
    is_load  = ctrl.exec && (opcode == op_load);
    is_arith = ctrl.exec && (opcode == op_add || opcode == op_sub || opcode == op_mul);
  end

  // a load pushes the RAM data one cycle late, at the end of mem.
  assign push_en  = is_push || (ctrl.mem && load_pend);
  assign push_val = load_pend ? rd_data : insn.fields.operand;
  assign pop_en   = is_arith || is_store;

  // ----------------------------------------------------------------------
  // ALU on the two top entries
  // ----------------------------------------------------------------------
  assign prod = stk[1] * stk[0];

  always_comb begin
    case (opcode)
      op_add:  alu_res = stk[1] + stk[0];
      op_sub:  alu_res = stk[1] - stk[0]; // second minus top.
      op_mul:  alu_res = prod[data_w-1:0];
      default: alu_res = stk[1];          // plain pop for a store.
    endcase
  end

  // ----------------------------------------------------------------------
  // stack entries
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < stack_depth; i++) begin
        stk[i] <= '0;
      end
    end else if (push_en) begin
      // the bottom entry falls off a full stack.
      stk[0] <= push_val;
      for (int i = 1; i < stack_depth; i++) begin
        stk[i] <= stk[i-1];
      end
    end else if (pop_en) begin
      stk[0] <= alu_res;
      for (int i = 1; i < stack_depth - 1; i++) begin
        stk[i] <= stk[i+1];
      end
      stk[stack_depth-1] <= '0; // zero fill keeps an empty stack reading zero.
    end
  end

  // ----------------------------------------------------------------------
  // result register, load flag and store request
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      reg0      <= '0;
      reg0_wr   <= 1'b0;
      load_pend <= 1'b0;
    end else begin
      if (is_out) begin
        reg0 <= stk[0];
      end
      reg0_wr   <= is_out;  // strobe lands in the mem cycle.
      load_pend <= is_load;
    end
  end

  // the address is always the operand, so a load's read starts in exec.
  always_comb begin
    mem_req.we    = is_store;
    mem_req.addr  = insn.fields.operand;
    mem_req.wdata = stk[0];
  end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram import stack_cpu_pkg::*; (
  input  logic              clk,
  input  mem_req_t          mem_req,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [2**data_w];

  // write and registered read share one block.
  // a read of the cell being written returns the old byte.
  always_ff @(posedge clk) begin
    if (mem_req.we) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
    rd_data <= mem[mem_req.addr];
  end

endmodule

`default_nettype wire

// ==== stack_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_cpu_top import stack_cpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  insn_u             insn,     // from the program memory at pc.
  output logic [pc_w-1:0]   pc,
  output logic [data_w-1:0] reg0,
  output logic              reg0_wr,
  output logic              halted
);

  ctrl_t             ctrl;
  mem_req_t          mem_req;
  logic [data_w-1:0] rd_data;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  cpu_sequencer u_sequencer (
    .clk    (clk),
    .rst    (rst),
    .insn   (insn),
    .ctrl   (ctrl),
    .halted (halted)
  );

  program_counter u_pc (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl),
    .pc   (pc)
  );

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------
  operand_stack u_stack (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .insn    (insn),
    .rd_data (rd_data),
    .mem_req (mem_req),
    .reg0    (reg0),
    .reg0_wr (reg0_wr)
  );

  data_ram u_ram (
    .clk     (clk),
    .mem_req (mem_req),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== stack_cpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_cpu_assert import stack_cpu_pkg::*; (
  input logic            clk,
  input logic            rst,
  input ctrl_t           ctrl,
  input mem_req_t        mem_req,
  input logic [pc_w-1:0] pc,
  input logic            reg0_wr,
  input logic            halted
);

  // ----------------------------------------------------------------------
  // phase and strobe rules
  // ----------------------------------------------------------------------
  strobe_after_exec: assert property (@(posedge clk) disable iff (rst)
    reg0_wr |-> $past(ctrl.exec))
    else $error("reg0_wr is high without an exec cycle before it.");

  we_in_exec: assert property (@(posedge clk) disable iff (rst)
    mem_req.we |-> ctrl.exec)   // stores are only issued from exec.
    else $error("a RAM write was requested outside exec.");

  pc_frozen: assert property (@(posedge clk) disable iff (rst)
    halted |=> $stable(pc))
    else $error("pc moved while the core was halted.");

  no_strobe_halted: assert property (@(posedge clk) disable iff (rst)
    $rose(reg0_wr) |-> !halted)
    else $error("reg0_wr rose while the core was halted.");

endmodule

bind stack_cpu_top stack_cpu_assert u_assert (
  .clk     (clk),
  .rst     (rst),
  .ctrl    (ctrl),
  .mem_req (mem_req),
  .pc      (pc),
  .reg0_wr (reg0_wr),
  .halted  (halted)
);

`default_nettype wire

// ==== stack_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_cpu_tb import stack_cpu_pkg::*; ();

  localparam int n_progs      = 12;
  localparam int min_len      = 40;
  localparam int max_len      = 60;
  localparam int reset_cycles = 8;
  localparam int tail_cycles  = 6;
  localparam int cycle_limit  = n_progs * (2 * (max_len + 1) + 20);

  logic              clk;
  logic              rst;
  insn_u             insn;
  logic [pc_w-1:0]   pc;
  logic [data_w-1:0] reg0;
  logic              reg0_wr;
  logic              halted;

  logic [15:0] prog [2**pc_w];   // program memory read at pc.
  logic [31:0] lfsr;
  logic [7:0]  m_stk [stack_depth];
  logic [7:0]  m_mem [256];
  logic [7:0]  exp_q [$];        // expected reg0 values in order.
  logic [7:0]  stored_q [$];     // addresses stored so far in this program.
  int          n_insn;
  int          cycles = 0;

  stack_cpu_top dut (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .reg0    (reg0),
    .reg0_wr (reg0_wr),
    .halted  (halted)
  );

  assign insn = prog[pc]; // the program memory answers in the same cycle.

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // ----------------------------------------------------------------------
  // random numbers and program generation
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = next_lfsr(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  task automatic build_program();
    int         len;
    int         sel;
    logic [7:0] opnd;
    stored_q.delete();
    len = min_len + int'(take_bits(5) % (max_len - min_len + 1));
    for (int a = 0; a < len; a++) begin
      sel  = int'(take_bits(4));
      opnd = 8'(take_bits(8));
      // pushes and pops are equally likely, so the stack drifts to both edges.
      case (sel)
        0, 1, 2, 3: prog[a] = {op_push, opnd};
        4, 5, 15:   prog[a] = {op_out, opnd};
        6, 14:      prog[a] = {op_add, opnd};
        7:          prog[a] = {op_sub, opnd};
        8:          prog[a] = {op_mul, opnd};
        9, 10: begin
          prog[a] = {op_store, opnd};
          stored_q.push_back(opnd);
        end
        11, 12: begin
          // a load only reads back a cell that this program has written.
          if (stored_q.size() > 0) begin
            prog[a] = {op_load, stored_q[take_bits(4) % stored_q.size()]};
          end else begin
            prog[a] = {op_push, opnd};
          end
        end
        default: prog[a] = {8'h08 + 8'(take_bits(7)), opnd}; // undefined opcode.
      endcase
    end
    prog[len] = halt_word;
    n_insn    = len;
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic void push_entry(input logic [7:0] v);
    for (int i = stack_depth - 1; i > 0; i--) begin
      m_stk[i] = m_stk[i-1];
    end
    m_stk[0] = v;   // the bottom entry is lost on a full stack.
  endfunction

  function automatic void pop_entry();
    for (int i = 0; i < stack_depth - 1; i++) begin
      m_stk[i] = m_stk[i+1];
    end
    m_stk[stack_depth-1] = 8'h00;
  endfunction

  task automatic predict_outputs();
    logic [7:0] op;
    logic [7:0] arg;
    logic [7:0] top;
    logic [7:0] second;
    for (int i = 0; i < stack_depth; i++) begin
      m_stk[i] = 8'h00;
    end
    exp_q.delete();
    for (int k = 0; k < n_insn; k++) begin
      op  = prog[k][15:8];
      arg = prog[k][7:0];
      case (op)
        op_push: push_entry(arg);
        op_out:  exp_q.push_back(m_stk[0]);
        op_add, op_sub, op_mul: begin
          top    = m_stk[0];
          second = m_stk[1];
          pop_entry();
          pop_entry();
          if (op == op_add) begin
            push_entry(second + top);
          end else if (op == op_sub) begin
            push_entry(second - top);
          end else begin
            push_entry(second * top);   // low byte of the product.
          end
        end
        op_store: begin
          m_mem[arg] = m_stk[0];
          pop_entry();
        end
        op_load: push_entry(m_mem[arg]);
        default: ;
      endcase
    end
  endtask

  // ----------------------------------------------------------------------
  // running and checking one program
  // ----------------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic run_program(input int p);
    int         pulses;
    logic [7:0] exp_reg0;
    pulses   = 0;
    exp_reg0 = 8'h00;   // reg0 clears on reset and holds between pulses.
    rst = 1'b1;
    build_program();
    predict_outputs();
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    // k counts falling edges since reset release and steps twice per instruction.
    for (int k = 0; k <= 2 * n_insn + 1; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      assert (halted == (k > 2 * n_insn))
        else report_fail($sformatf("program %0d halted is %0b at cycle %0d", p, halted, k));
      assert (int'(pc) == k / 2)
        else report_fail($sformatf("program %0d pc is %0d at cycle %0d", p, pc, k));
      if (reg0_wr) begin
        assert (pulses < exp_q.size())
          else report_fail($sformatf("program %0d has an extra reg0_wr pulse", p));
        exp_reg0 = exp_q[pulses];
        pulses++;
      end
      assert (reg0 == exp_reg0)
        else report_fail($sformatf("program %0d reg0 is %02h, expected %02h at cycle %0d",
                                   p, reg0, exp_reg0, k));
    end
    repeat (tail_cycles) begin
      @(negedge clk);
      assert (halted && int'(pc) == n_insn && !reg0_wr && reg0 == exp_reg0)
        else report_fail($sformatf("program %0d moved after the halt word", p));
    end
    assert (pulses == exp_q.size())
      else report_fail($sformatf("program %0d gave %0d outputs, expected %0d",
                                 p, pulses, exp_q.size()));
    $display("program %0d: %0d instructions, %0d outputs", p, n_insn, pulses);
  endtask

  initial begin
    rst  = 1'b1;
    lfsr = 32'h8d3e34c4;
    for (int p = 0; p < n_progs; p++) begin
      run_program(p);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
stack_cpu_pkg.sv
cpu_sequencer.sv
program_counter.sv
operand_stack.sv
data_ram.sv
stack_cpu_top.sv
stack_cpu_assert.sv
stack_cpu_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module stack_cpu_tb -f build.f
	out=$$(./obj_dir/Vstack_cpu_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
